// ==== Bender.yml ====
package:
  name: eth_tx_ofm

sources:
  - files:
      - hw/eth_tx_pkg.sv
      - hw/eth_tx_dispatch.sv
      - hw/eth_tx_slot.sv
      - hw/eth_tx_drain.sv
      - hw/eth_tx_ofm.sv
  - target: test
    files:
      - test/tb_eth_tx_ofm.sv

// ==== filelist.f ====
hw/eth_tx_pkg.sv
hw/eth_tx_dispatch.sv
hw/eth_tx_slot.sv
hw/eth_tx_drain.sv
hw/eth_tx_ofm.sv
test/tb_eth_tx_ofm.sv

// ==== hw/eth_tx_dispatch.sv ====
// Pairs each DMA data frame with its two control words
// Control stream must deliver exactly header then application word per frame
// Kept frames go to the slots in round-robin order, dropped ones are swallowed
// A kept frame longer than max_beats is illegal
`timescale 1ns/1ns
`default_nettype none

module eth_tx_dispatch (
   input  logic                              mm2s_clk,
   input  logic                              rst_n,
   input  logic [eth_tx_pkg::ctrl_w-1:0]     txc_tdata,
   input  logic                              txc_tlast,
   input  logic                              txc_tvalid,
   output logic                              txc_tready,
   input  logic [eth_tx_pkg::data_w-1:0]     txd_tdata,
   input  logic [eth_tx_pkg::keep_w-1:0]     txd_tkeep,
   input  logic                              txd_tlast,
   input  logic                              txd_tvalid,
   output logic                              txd_tready,
   input  logic [eth_tx_pkg::num_slots-1:0]  slot_free,
   output logic [eth_tx_pkg::num_slots-1:0]  wr_en,
   output logic [eth_tx_pkg::data_w-1:0]     wr_data,
   output logic [eth_tx_pkg::keep_w-1:0]     wr_keep,
   output logic                              wr_last,
   output logic                              wr_bad,
   output logic [15:0]                       drop_count
);
   import eth_tx_pkg::*;

   logic [state_w-1:0]    state;
   logic [slot_ptr_w-1:0] ptr;        // Next slot to fill
   logic                  keep_frm;   // Header flag was good
   logic                  bad_q;      // mark_bad of current frame
   logic [beat_cnt_w-1:0] beat_cnt;   // Beats already written to the slot
   tx_ctrl_word_t         ctrl_word;
   logic                  txc_fire;
   logic                  txd_fire;

   assign ctrl_word  = txc_tdata;
   assign txc_tready = (state == st_hdr) || (state == st_app);
   assign txc_fire   = txc_tvalid && txc_tready;

   // Slot must be empty at frame start; after that the slot is ours
   assign txd_tready = (state == st_data) &&
                       (!keep_frm || slot_free[ptr] || (beat_cnt != '0));
   assign txd_fire   = txd_tvalid && txd_tready;

   always_comb
   begin
      wr_en      = '0;
      wr_en[ptr] = txd_fire && keep_frm;   // Dropped beats go nowhere
   end

   assign wr_data = txd_tdata;   // Shared write bus, wr_en selects
   assign wr_keep = txd_tkeep;
   assign wr_last = txd_tlast;
   assign wr_bad  = bad_q;

   always_ff @(posedge mm2s_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state      <= st_hdr;
         ptr        <= '0;
         keep_frm   <= 1'b0;
         beat_cnt   <= '0;
         drop_count <= '0;
      end
      else
      begin
         case (state)
            st_hdr:
            begin
               if (txc_fire)
               begin
                  keep_frm <= (ctrl_word.hdr.flag == hdr_flag_ok);   // Keep or drop
                  state    <= st_app;
               end
            end
            st_app:
            begin
               if (txc_fire)
                  state <= st_data;
            end
            st_data:
            begin
               if (txd_fire)
               begin
                  if (keep_frm)
                     beat_cnt <= beat_cnt + 1'b1;
                  if (txd_tlast)
                  begin
                     state    <= st_hdr;
                     beat_cnt <= '0;
                     if (keep_frm)
                        ptr <= ptr + 1'b1;                  // Drain follows same order
                     else
                        drop_count <= drop_count + 1'b1;   // Wraps at 16 bits
                  end
               end
            end
            default:
               state <= st_hdr;
         endcase
      end
   end

   // Latched with the application word, valid for the whole data phase
   always_ff @(posedge mm2s_clk)
   begin
      if (txc_fire && (state == st_app))
         bad_q <= ctrl_word.app.mark_bad;
   end

   // DMA puts tlast on the application word and nowhere else
   a_ctrl_last: assert property (@(posedge mm2s_clk) disable iff (!rst_n)
      txc_fire |-> (txc_tlast == (state == st_app)));

   // Kept frame must fit in one slot
   a_frame_len: assert property (@(posedge mm2s_clk) disable iff (!rst_n)
      (txd_fire && keep_frm) |-> (beat_cnt < max_beats));

endmodule

`default_nettype wire

// ==== hw/eth_tx_drain.sv ====
// Reads complete frames from the slots in round-robin order
// Order matches the dispatcher, both pointers move on a frame's last beat
// Output is one registered beat, full throughput while tready stays high
`timescale 1ns/1ns
`default_nettype none

module eth_tx_drain (
   input  logic                              mm2s_clk,
   input  logic                              rst_n,
   input  logic [eth_tx_pkg::num_slots-1:0]  rd_valid,
   input  logic [eth_tx_pkg::data_w-1:0]     rd_data [eth_tx_pkg::num_slots],
   input  logic [eth_tx_pkg::keep_w-1:0]     rd_keep [eth_tx_pkg::num_slots],
   input  logic [eth_tx_pkg::num_slots-1:0]  rd_last,
   input  logic [eth_tx_pkg::num_slots-1:0]  rd_bad,
   output logic [eth_tx_pkg::num_slots-1:0]  rd_en,
   output logic [eth_tx_pkg::data_w-1:0]     tx_axis_mac_tdata,
   output logic [eth_tx_pkg::keep_w-1:0]     tx_axis_mac_tkeep,
   output logic                              tx_axis_mac_tlast,
   output logic                              tx_axis_mac_tuser,
   output logic                              tx_axis_mac_tvalid,
   input  logic                              tx_axis_mac_tready
);
   import eth_tx_pkg::*;

   logic [slot_ptr_w-1:0] ptr;        // Slot being drained
   logic                  can_load;   // Output register empty or leaving
   logic                  pop;

   assign can_load = !tx_axis_mac_tvalid || tx_axis_mac_tready;
   assign pop      = can_load && rd_valid[ptr];

   always_comb
   begin
      rd_en      = '0;
      rd_en[ptr] = pop;   // One-cycle pop of the pointed slot
   end

   always_ff @(posedge mm2s_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         ptr                <= '0;
         tx_axis_mac_tvalid <= 1'b0;
      end
      else if (pop)
      begin
         tx_axis_mac_tvalid <= 1'b1;
         if (rd_last[ptr])
            ptr <= ptr + 1'b1;   // Frame done, move on
      end
      else if (tx_axis_mac_tready)
         tx_axis_mac_tvalid <= 1'b0;   // Beat taken, nothing new
   end

   // Beat register, loads only on a pop
   always_ff @(posedge mm2s_clk)
   begin
      if (pop)
      begin
         tx_axis_mac_tdata <= rd_data[ptr];
         tx_axis_mac_tkeep <= rd_keep[ptr];
         tx_axis_mac_tlast <= rd_last[ptr];
         tx_axis_mac_tuser <= rd_bad[ptr] && rd_last[ptr];   // Bad mark on last beat only
      end
   end

   // MAC stream rule, beat frozen while stalled
   a_out_hold: assert property (@(posedge mm2s_clk) disable iff (!rst_n)
      (tx_axis_mac_tvalid && !tx_axis_mac_tready) |=>
         (tx_axis_mac_tvalid && $stable(tx_axis_mac_tdata) &&
          $stable(tx_axis_mac_tkeep) && $stable(tx_axis_mac_tlast) &&
          $stable(tx_axis_mac_tuser)));

endmodule

`default_nettype wire

// ==== hw/eth_tx_ofm.sv ====
// MM2S transmit bridge, DMA control and data streams to the 10G MAC stream
// Single clock domain, everything on mm2s_clk
// Frames are stored whole before sending, so the MAC never underruns
// Up to num_slots frames in flight, at most max_beats beats each
`timescale 1ns/1ns
`default_nettype none

module eth_tx_ofm (
   input  logic                                mm2s_clk,
   input  logic                                rst_n,
   input  logic [eth_tx_pkg::ctrl_w-1:0]       txc_tdata,
   input  logic [eth_tx_pkg::ctrl_keep_w-1:0]  txc_tkeep,
   input  logic                                txc_tlast,
   input  logic                                txc_tvalid,
   output logic                                txc_tready,
   input  logic [eth_tx_pkg::data_w-1:0]       txd_tdata,
   input  logic [eth_tx_pkg::keep_w-1:0]       txd_tkeep,
   input  logic                                txd_tlast,
   input  logic                                txd_tvalid,
   output logic                                txd_tready,
   output logic [eth_tx_pkg::data_w-1:0]       tx_axis_mac_tdata,
   output logic [eth_tx_pkg::keep_w-1:0]       tx_axis_mac_tkeep,
   output logic                                tx_axis_mac_tlast,
   output logic                                tx_axis_mac_tuser,
   output logic                                tx_axis_mac_tvalid,
   input  logic                                tx_axis_mac_tready,
   output logic [15:0]                         drop_count
);
   import eth_tx_pkg::*;

   // Dispatcher to slots, write bus shared
   logic [num_slots-1:0] slot_free;
   logic [num_slots-1:0] wr_en;
   logic [data_w-1:0]    wr_data;
   logic [keep_w-1:0]    wr_keep;
   logic                 wr_last;
   logic                 wr_bad;

   // Slots to drain, one lane per slot
   logic [num_slots-1:0] rd_valid;
   logic [num_slots-1:0] rd_en;
   logic [data_w-1:0]    rd_data [num_slots];
   logic [keep_w-1:0]    rd_keep [num_slots];
   logic [num_slots-1:0] rd_last;
   logic [num_slots-1:0] rd_bad;

   eth_tx_dispatch i_dispatch (
      .mm2s_clk   (mm2s_clk),
      .rst_n      (rst_n),
      .txc_tdata  (txc_tdata),
      .txc_tlast  (txc_tlast),
      .txc_tvalid (txc_tvalid),
      .txc_tready (txc_tready),
      .txd_tdata  (txd_tdata),
      .txd_tkeep  (txd_tkeep),
      .txd_tlast  (txd_tlast),
      .txd_tvalid (txd_tvalid),
      .txd_tready (txd_tready),
      .slot_free  (slot_free),
      .wr_en      (wr_en),
      .wr_data    (wr_data),
      .wr_keep    (wr_keep),
      .wr_last    (wr_last),
      .wr_bad     (wr_bad),
      .drop_count (drop_count)
   );

   for (genvar i = 0; i < num_slots; i++)
   begin : g_slot
      eth_tx_slot i_slot (
         .mm2s_clk  (mm2s_clk),
         .rst_n     (rst_n),
         .wr_en     (wr_en[i]),
         .wr_data   (wr_data),
         .wr_keep   (wr_keep),
         .wr_last   (wr_last),
         .wr_bad    (wr_bad),
         .slot_free (slot_free[i]),
         .rd_en     (rd_en[i]),
         .rd_valid  (rd_valid[i]),
         .rd_data   (rd_data[i]),
         .rd_keep   (rd_keep[i]),
         .rd_last   (rd_last[i]),
         .rd_bad    (rd_bad[i])
      );
   end

   eth_tx_drain i_drain (
      .mm2s_clk           (mm2s_clk),
      .rst_n              (rst_n),
      .rd_valid           (rd_valid),
      .rd_data            (rd_data),
      .rd_keep            (rd_keep),
      .rd_last            (rd_last),
      .rd_bad             (rd_bad),
      .rd_en              (rd_en),
      .tx_axis_mac_tdata  (tx_axis_mac_tdata),
      .tx_axis_mac_tkeep  (tx_axis_mac_tkeep),
      .tx_axis_mac_tlast  (tx_axis_mac_tlast),
      .tx_axis_mac_tuser  (tx_axis_mac_tuser),
      .tx_axis_mac_tvalid (tx_axis_mac_tvalid),
      .tx_axis_mac_tready (tx_axis_mac_tready)
   );

   // Control words are always full 32-bit words from the DMA
   a_ctrl_keep: assert property (@(posedge mm2s_clk) disable iff (!rst_n)
      (txc_tvalid && txc_tready) |-> (&txc_tkeep));

endmodule

`default_nettype wire

// ==== hw/eth_tx_pkg.sv ====
// Shared widths, slot geometry and control-word layout for the MM2S transmit bridge
// num_slots must be a power of two, 2 or more
// One slot holds max_beats data beats, which is the frame size limit
`default_nettype none

package eth_tx_pkg;

   localparam int data_w      = 64;           // Data beat
   localparam int keep_w      = data_w / 8;   // One keep bit per byte
   localparam int ctrl_w      = 32;           // Control word
   localparam int ctrl_keep_w = ctrl_w / 8;
   localparam int num_slots   = 2;
   localparam int slot_ptr_w  = $clog2(num_slots);
   localparam int max_beats   = 16;
   localparam int beat_ptr_w  = $clog2(max_beats);
   localparam int beat_cnt_w  = beat_ptr_w + 1;   // Must reach max_beats itself

   localparam logic [3:0] hdr_flag_ok = 4'hA;     // Valid header pattern

   // Dispatcher FSM encoding
   localparam int state_w = 2;
   localparam logic [state_w-1:0] st_hdr  = 2'd0;  // Waiting for header word
   localparam logic [state_w-1:0] st_app  = 2'd1;  // Waiting for application word
   localparam logic [state_w-1:0] st_data = 2'd2;  // Moving data beats

   // First control word
   typedef struct packed {
      logic [3:0]  flag;       // hdr_flag_ok or the frame is dropped
      logic [11:0] reserved;
      logic [15:0] tag;
   } tx_ctrl_hdr_t;

   // Second control word, carries tlast
   typedef struct packed {
      logic [30:0] reserved;   // Checksum offload etc, not handled
      logic        mark_bad;   // Forces MAC tuser on last beat
   } tx_ctrl_app_t;

   // Word position in the frame picks the view
   typedef union packed {
      tx_ctrl_hdr_t hdr;
      tx_ctrl_app_t app;
   } tx_ctrl_word_t;

endpackage

`default_nettype wire

// ==== hw/eth_tx_slot.sv ====
// Store-and-forward buffer for one frame of up to max_beats beats
// Read side sees nothing until the last beat is written
// Writer must wait for slot_free, reader must wait for rd_valid
`timescale 1ns/1ns
`default_nettype none

module eth_tx_slot (
   input  logic                           mm2s_clk,
   input  logic                           rst_n,
   input  logic                           wr_en,
   input  logic [eth_tx_pkg::data_w-1:0]  wr_data,
   input  logic [eth_tx_pkg::keep_w-1:0]  wr_keep,
   input  logic                           wr_last,
   input  logic                           wr_bad,
   output logic                           slot_free,
   input  logic                           rd_en,
   output logic                           rd_valid,
   output logic [eth_tx_pkg::data_w-1:0]  rd_data,
   output logic [eth_tx_pkg::keep_w-1:0]  rd_keep,
   output logic                           rd_last,
   output logic                           rd_bad
);
   import eth_tx_pkg::*;

   logic [data_w-1:0]     data_mem [max_beats];
   logic [keep_w-1:0]     keep_mem [max_beats];
   logic [max_beats-1:0]  last_mem;
   logic [beat_ptr_w-1:0] wr_ptr;
   logic [beat_ptr_w-1:0] rd_ptr;
   logic                  complete;   // Whole frame stored
   logic                  pop_last;

   assign pop_last  = rd_en && rd_last;
   assign slot_free = !complete && (wr_ptr == '0);   // Nothing written yet

   // Asynchronous read, next beat appears right after each pop
   assign rd_data = data_mem[rd_ptr];
   assign rd_keep = keep_mem[rd_ptr];
   assign rd_last = last_mem[rd_ptr];

   always_ff @(posedge mm2s_clk)
   begin
      if (wr_en)
      begin
         data_mem[wr_ptr] <= wr_data;
         keep_mem[wr_ptr] <= wr_keep;
         last_mem[wr_ptr] <= wr_last;
      end
      if (wr_en && wr_last)
         rd_bad <= wr_bad;   // One flag per stored frame
   end

   always_ff @(posedge mm2s_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         complete <= 1'b0;
         rd_valid <= 1'b0;
      end
      else
      begin
         if (wr_en)
         begin
            wr_ptr <= wr_ptr + 1'b1;   // Wraps to 0 on a 16-beat frame, complete covers it
            if (wr_last)
               complete <= 1'b1;
         end
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
         if (pop_last)
         begin
            complete <= 1'b0;   // Slot empty again
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            rd_valid <= 1'b0;
         end
         else
            rd_valid <= complete;   // Extra cycle before the drain sees it
      end
   end

   // Dispatcher honours slot_free
   a_no_overwrite: assert property (@(posedge mm2s_clk) disable iff (!rst_n)
      complete |-> !wr_en);

   // Drain pops only a presented frame
   a_no_underrun: assert property (@(posedge mm2s_clk) disable iff (!rst_n)
      rd_en |-> rd_valid);

endmodule

`default_nettype wire

// ==== test/tb_eth_tx_ofm.sv ====
// Random traffic testbench for the MM2S transmit bridge
// Expected MAC beats come from the kept frames as sent
// Concurrent assertions compare each MAC transfer with the oldest expected beat
// Inputs change on the falling clock edge and outputs are sampled on the rising edge
// At most exp_depth kept beats per run
`timescale 1ns/1ns
`default_nettype none

module tb_eth_tx_ofm;
   import eth_tx_pkg::*;

   localparam int clk_half    = 4;                      // 8 ns period
   localparam int frames_each = 60;                     // Frames per traffic test
   localparam int exp_depth   = 4096;
   localparam int beat_bits   = data_w + keep_w + 2;    // data, keep, last, user
   localparam logic [3:0] good_flag = 4'hA;
   // Worst case beats including control words at 4 cycles each plus margin
   localparam int watchdog_ns = 2 * frames_each * (max_beats + 2) * 4 * 2 * clk_half + 10000;

   logic                 mm2s_clk;
   logic                 rst_n;
   logic [ctrl_w-1:0]    txc_tdata;
   logic [3:0]           txc_tkeep;
   logic                 txc_tlast;
   logic                 txc_tvalid;
   logic                 txc_tready;
   logic [data_w-1:0]    txd_tdata;
   logic [keep_w-1:0]    txd_tkeep;
   logic                 txd_tlast;
   logic                 txd_tvalid;
   logic                 txd_tready;
   logic [data_w-1:0]    tx_axis_mac_tdata;
   logic [keep_w-1:0]    tx_axis_mac_tkeep;
   logic                 tx_axis_mac_tlast;
   logic                 tx_axis_mac_tuser;
   logic                 tx_axis_mac_tvalid;
   logic                 tx_axis_mac_tready;
   logic [15:0]          drop_count;

   logic [beat_bits-1:0] exp_mem [exp_depth];   // Reference queue storage
   int                   wr_idx;                // Written by the frame driver
   int                   rd_idx;                // Advances once per MAC transfer
   logic [beat_bits-1:0] exp_front;
   logic [beat_bits-1:0] act_beat;
   int                   exp_drops;
   int                   err_count;
   int                   test_count;
   int                   fail_count;
   bit                   random_ready;
   string                cur_test;

   eth_tx_ofm i_dut (.*);

   assign exp_front = exp_mem[rd_idx];
   assign act_beat  = {tx_axis_mac_tdata, tx_axis_mac_tkeep, tx_axis_mac_tlast,
                       tx_axis_mac_tuser};

   initial
   begin
      mm2s_clk = 1'b0;
      forever #clk_half mm2s_clk = ~mm2s_clk;
   end

   initial
   begin
      #(watchdog_ns);
      $display("Timeout, the MAC stream stopped before all expected beats arrived");
      $display("Test failed");
      $finish;
   end

   // Random bursts of MAC back-pressure
   always @(negedge mm2s_clk)
   begin
      if (!random_ready)
         tx_axis_mac_tready = 1'b1;
      else if ($urandom_range(3, 0) == 0)
         tx_axis_mac_tready = ~tx_axis_mac_tready;
   end

   always @(posedge mm2s_clk)
   begin
      if (rst_n && tx_axis_mac_tvalid && tx_axis_mac_tready)
         rd_idx <= rd_idx + 1;   // Pop after the assertions sampled the front
   end

   a_beat_expected: assert property (@(posedge mm2s_clk) disable iff (!rst_n)
      (tx_axis_mac_tvalid && tx_axis_mac_tready) |-> (rd_idx < wr_idx))
      else
      begin
         err_count++;
         $display("%s: MAC beat arrived with no beat expected", cur_test);
      end

   a_beat_value: assert property (@(posedge mm2s_clk) disable iff (!rst_n)
      (tx_axis_mac_tvalid && tx_axis_mac_tready && (rd_idx < wr_idx)) |->
         (act_beat == exp_front))
      else
      begin
         err_count++;
         $display("mismatch %s: beat %0d expected %h actual %h", cur_test,
                  $sampled(rd_idx), $sampled(exp_front), $sampled(act_beat));
      end

   // No bubbles once a stored frame has started
   a_no_gap: assert property (@(posedge mm2s_clk) disable iff (!rst_n)
      (tx_axis_mac_tvalid && tx_axis_mac_tready && !tx_axis_mac_tlast) |=>
         tx_axis_mac_tvalid)
      else
      begin
         err_count++;
         $display("%s: gap inside a frame on the MAC stream", cur_test);
      end

   a_hold: assert property (@(posedge mm2s_clk) disable iff (!rst_n)
      (tx_axis_mac_tvalid && !tx_axis_mac_tready) |=>
         (tx_axis_mac_tvalid && $stable(act_beat)))
      else
      begin
         err_count++;
         $display("%s: MAC beat changed or vanished while stalled", cur_test);
      end

   a_user_last: assert property (@(posedge mm2s_clk) disable iff (!rst_n)
      (tx_axis_mac_tvalid && tx_axis_mac_tuser) |-> tx_axis_mac_tlast)
      else
      begin
         err_count++;
         $display("%s: tuser set on a beat that is not last", cur_test);
      end

   task automatic send_ctrl(input logic [ctrl_w-1:0] word, input logic last);
      @(negedge mm2s_clk);
      txd_tvalid = 1'b0;
      txc_tdata  = word;
      txc_tlast  = last;
      txc_tvalid = 1'b1;
      @(posedge mm2s_clk);
      while (!txc_tready)
         @(posedge mm2s_clk);
   endtask

   task automatic send_beat(input logic [data_w-1:0] data, input logic [keep_w-1:0] keep,
                            input logic last, input logic kept, input logic bad);
      @(negedge mm2s_clk);
      txc_tvalid = 1'b0;
      txd_tdata  = data;
      txd_tkeep  = keep;
      txd_tlast  = last;
      txd_tvalid = 1'b1;
      @(posedge mm2s_clk);
      while (!txd_tready)
         @(posedge mm2s_clk);
      if (kept)
      begin
         exp_mem[wr_idx] = {data, keep, last, bad && last};   // tuser only on last
         wr_idx++;
      end
   endtask

   task automatic send_frame();
      int                len;
      int                r;
      logic              good;
      logic              bad;
      logic [3:0]        flag;
      logic [keep_w-1:0] keep;
      len  = $urandom_range(max_beats, 1);
      good = ($urandom_range(3, 0) != 0);   // 3 in 4 kept
      bad  = ($urandom_range(3, 0) == 0);   // 1 in 4 marked bad
      r    = $urandom_range(14, 0);
      flag = good ? good_flag : ((r < 10) ? 4'(r) : 4'(r + 1));   // Any nibble but A
      send_ctrl({flag, 12'($urandom), 16'($urandom)}, 1'b0);
      send_ctrl({31'($urandom), bad}, 1'b1);
      for (int i = 0; i < len; i++)
      begin
         keep = (i == len - 1) ? (8'hff >> $urandom_range(7, 0)) : 8'hff;
         send_beat({$urandom, $urandom}, keep, i == len - 1, good, bad);
      end
      if (!good)
         exp_drops++;
   endtask

   task automatic finish_test(input int errs_before);
      test_count++;
      if (err_count == errs_before)
         $display("%s: ok", cur_test);
      else
      begin
         fail_count++;
         $display("%s: FAILED with %0d errors", cur_test, err_count - errs_before);
      end
   endtask

   task automatic check_reset();
      int errs_before;
      errs_before = err_count;
      cur_test    = "reset_values";
      assert (!tx_axis_mac_tvalid && !txd_tready && txc_tready)
      else
      begin
         err_count++;
         $display("mismatch %s: valid/ready expected 001 actual %b%b%b", cur_test,
                  tx_axis_mac_tvalid, txd_tready, txc_tready);
      end
      assert (drop_count == 16'd0)
      else
      begin
         err_count++;
         $display("mismatch %s: drop_count expected 0 actual %0d", cur_test, drop_count);
      end
      finish_test(errs_before);
   endtask

   task automatic run_traffic(input string name, input bit rnd_ready, input int frames);
      int errs_before;
      errs_before  = err_count;
      cur_test     = name;
      random_ready <= rnd_ready;
      for (int f = 0; f < frames; f++)
      begin
         send_frame();
         repeat ($urandom_range(2, 0))
         begin
            @(negedge mm2s_clk);
            txd_tvalid = 1'b0;   // Idle between frames now and then
         end
      end
      @(negedge mm2s_clk);
      txc_tvalid = 1'b0;
      txd_tvalid = 1'b0;
      while (rd_idx != wr_idx)
         @(posedge mm2s_clk);
      repeat (2)
         @(negedge mm2s_clk);   // Drop count lags the last beat by a cycle
      assert (drop_count == 16'(exp_drops))
      else
      begin
         err_count++;
         $display("mismatch %s: drop_count expected %0d actual %0d", cur_test,
                  exp_drops, drop_count);
      end
      assert (!tx_axis_mac_tvalid)
      else
      begin
         err_count++;
         $display("%s: MAC stream still valid after the last expected beat", cur_test);
      end
      finish_test(errs_before);
   endtask

   initial
   begin
      void'($urandom(32'h7522a57c));
      rst_n              = 1'b0;
      txc_tdata          = '0;
      txc_tkeep          = 4'hf;   // Full control words only
      txc_tlast          = 1'b0;
      txc_tvalid         = 1'b0;
      txd_tdata          = '0;
      txd_tkeep          = '0;
      txd_tlast          = 1'b0;
      txd_tvalid         = 1'b0;
      tx_axis_mac_tready = 1'b1;
      random_ready       = 1'b0;
      wr_idx             = 0;
      rd_idx             = 0;
      exp_drops          = 0;
      err_count          = 0;
      test_count         = 0;
      fail_count         = 0;
      cur_test           = "reset";
      repeat (5)
         @(posedge mm2s_clk);
      @(negedge mm2s_clk);
      rst_n = 1'b1;
      check_reset();
      run_traffic("steady_ready", 1'b0, frames_each);
      run_traffic("random_ready", 1'b1, frames_each);
      $display("tests %0d, failed %0d, errors %0d, beats %0d, drops %0d",
               test_count, fail_count, err_count, rd_idx, exp_drops);
      if (err_count == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire
